/* common/logger_pkg.sv */
// shared widths, register map, config field positions and record layout
// of the event logger, imported by every logger module
package logger_pkg;

    localparam int GPIO_N     = 10;             // gpio input pins
    localparam int CFG_ADDR_W = 2;              // register address width
    localparam int WORD_W     = 16;             // logged word
    localparam int TS_W       = 32;             // local timestamp
    localparam int CHAN_W     = 2;              // channel code in header msbs
    localparam int SEQ_W      = WORD_W - CHAN_W; // rest of header is sequence
    localparam int PPS_SEL_W  = 2;              // pps pin select field
    localparam int MSG_SEL_W  = 4;              // msg trigger pin index field

    typedef logic [GPIO_N-1:0]     gpio_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [TS_W-1:0]       tstamp_t;
    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
    typedef logic [CHAN_W-1:0]     chan_t;
    typedef logic [SEQ_W-1:0]      seq_t;

    // packer states, one record word per state after IDLE
    typedef enum logic [2:0] {IDLE, HDR, TS_LO, TS_HI, PAYLOAD} pk_state_t;

    localparam cfg_addr_t ADDR_CONFIG  = 2'd0;   // configuration word
    localparam cfg_addr_t ADDR_MESSAGE = 2'd1;   // message word, low 16 bits

    localparam int CONF_PPS_SEL_LSB = 0;         // 1 - pin 2, 2 - pin 4, else off
    localparam int CONF_PPS_INV     = 2;
    localparam int CONF_MSG_SEL_LSB = 4;         // trigger pin index
    localparam int CONF_MSG_INV     = 8;
    localparam int CONF_EN          = 12;        // logger enable

    localparam logic [MSG_SEL_W-1:0] MSG_SEL_OFF = 4'hf; // trigger disabled
    localparam int PPS_PIN_A = 2;                // pps pin for select value 1
    localparam int PPS_PIN_B = 4;                // pps pin for select value 2

    localparam int DENOISE_CYCLES = 8;           // stable cycles before filter follows
    localparam int DENOISE_W      = $clog2(DENOISE_CYCLES);

    // record: header {chan, seq}, ts[15:0], ts[31:16], payload
    localparam int    RECORD_WORDS = 4;
    localparam chan_t CHAN_PPS     = 2'd0;
    localparam chan_t CHAN_MSG     = 2'd1;

endpackage

/* design/logger_regs.sv */
`timescale 1ns/1ps
// logger register block: config word and message word
// a write lands on the clock edge that samples i_cfg_we, visible next cycle
module logger_regs import logger_pkg::*; (
    input  logic                 xclk,
    input  logic                 config_rst,
    input  logic                 i_cfg_we,
    input  cfg_addr_t            i_cfg_addr,
    input  logic [31:0]          i_cfg_data,
    output logic [PPS_SEL_W-1:0] o_pps_sel,
    output logic                 o_pps_inv,
    output logic [MSG_SEL_W-1:0] o_msg_sel,
    output logic                 o_msg_inv,
    output logic                 o_logger_en,
    output word_t                o_msg_word
);

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            o_pps_sel   <= '0;             // pps channel off
            o_pps_inv   <= 1'b0;
            o_msg_sel   <= '0;
            o_msg_inv   <= 1'b0;
            o_logger_en <= 1'b0;           // logger off until software enables
            o_msg_word  <= '0;
        end else if (i_cfg_we) begin
            case (i_cfg_addr)
                ADDR_CONFIG: begin
                    o_pps_sel   <= i_cfg_data[CONF_PPS_SEL_LSB +: PPS_SEL_W];
                    o_pps_inv   <= i_cfg_data[CONF_PPS_INV];
                    o_msg_sel   <= i_cfg_data[CONF_MSG_SEL_LSB +: MSG_SEL_W];
                    o_msg_inv   <= i_cfg_data[CONF_MSG_INV];
                    o_logger_en <= i_cfg_data[CONF_EN];
                end
                ADDR_MESSAGE: begin
                    o_msg_word  <= i_cfg_data[WORD_W-1:0]; // upper half dropped
                end
                default: begin
                    // unmapped address, nothing stored
                end
            endcase
        end
    end

endmodule

/* design/pps_event.sv */
`timescale 1ns/1ps
// gps one-second pulse source: pin select, invert, glitch filter, rising edge
// each accepted pulse raises o_rq with the running pulse count as payload
module pps_event import logger_pkg::*; (
    input  logic                 xclk,
    input  logic                 config_rst,
    input  gpio_t                i_gpio,
    input  logic [PPS_SEL_W-1:0] i_pps_sel,
    input  logic                 i_pps_inv,
    input  logic                 i_logger_en,
    input  logic                 i_ack,        // one-cycle pulse from packer
    output logic                 o_rq,
    output word_t                o_payload
);

    logic                 pin_sel;     // selected pin, before invert
    logic                 pps_on;      // select code names a pin
    logic                 pps_in;
    logic [2:0]           pps_d;       // input shift stages
    logic                 filt;        // denoised level
    logic                 filt_d;      // edge stage
    logic [DENOISE_W-1:0] dn_cnt;      // cycles left before filt follows
    logic                 take;        // rising edge accepted as new request
    word_t                pulse_cnt;

    always_comb begin
        pps_on  = 1'b1;
        case (i_pps_sel)
            2'd1:    pin_sel = i_gpio[PPS_PIN_A];
            2'd2:    pin_sel = i_gpio[PPS_PIN_B];
            default: begin
                pin_sel = 1'b0;
                pps_on  = 1'b0;    // codes 0 and 3, channel off
            end
        endcase
    end

    assign pps_in = pps_on && (pin_sel ^ i_pps_inv); // off channel stays low with invert
    assign take   = i_logger_en && filt && !filt_d && !o_rq; // pending rq ignores new edge

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            pps_d  <= '0;
            filt   <= 1'b0;
            dn_cnt <= DENOISE_W'(DENOISE_CYCLES - 1);
        end else begin
            pps_d <= {pps_d[1:0], pps_in};
            if (pps_d[2] == filt) begin
                dn_cnt <= DENOISE_W'(DENOISE_CYCLES - 1); // agrees, restart window
            end else if (dn_cnt == '0) begin
                filt <= pps_d[2];  // new level held for the full window
            end else begin
                dn_cnt <= dn_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (config_rst || !i_logger_en) begin
            filt_d    <= 1'b1;   // a level already high at enable is no edge
            o_rq      <= 1'b0;
            pulse_cnt <= '0;     // first pulse after enable counts 1
        end else begin
            filt_d <= filt;
            if (filt && !filt_d) begin
                pulse_cnt <= pulse_cnt + 1'b1;
            end
            if (i_ack) begin
                o_rq <= 1'b0;    // drops the cycle after ack
            end else if (take) begin
                o_rq <= 1'b1;
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (take) begin
            o_payload <= pulse_cnt + 1'b1; // count including this pulse
        end
    end

endmodule

/* design/msg_event.sv */
`timescale 1ns/1ps
// message source: trigger pin by index, invert, 2-flop sync, rising edge
// a trigger latches the software message word and raises o_rq
module msg_event import logger_pkg::*; (
    input  logic                 xclk,
    input  logic                 config_rst,
    input  gpio_t                i_gpio,
    input  logic [MSG_SEL_W-1:0] i_msg_sel,
    input  logic                 i_msg_inv,
    input  logic                 i_logger_en,
    input  word_t                i_msg_word,
    input  logic                 i_ack,        // one-cycle pulse from packer
    output logic                 o_rq,
    output word_t                o_payload
);

    logic [2**MSG_SEL_W-1:0] gpio_x;    // pins padded to the full index range
    logic                    trig;
    logic [1:0]              trig_sync;
    logic                    trig_prev; // edge stage
    logic                    take;

    assign gpio_x = {{(2**MSG_SEL_W - GPIO_N){1'b0}}, i_gpio}; // indices past GPIO_N read 0
    assign trig   = (i_msg_sel != MSG_SEL_OFF) && (gpio_x[i_msg_sel] ^ i_msg_inv);
    assign take   = i_logger_en && trig_sync[1] && !trig_prev && !o_rq;

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            trig_sync <= '0;
        end else begin
            trig_sync <= {trig_sync[0], trig};  // 2 sync cycles
        end
    end

    always_ff @(posedge xclk) begin
        if (config_rst || !i_logger_en) begin
            trig_prev <= 1'b1;  // needs a low level before the next edge
            o_rq      <= 1'b0;
        end else begin
            trig_prev <= trig_sync[1];
            if (i_ack) begin
                o_rq <= 1'b0;
            end else if (take) begin
                o_rq <= 1'b1;   // 3rd cycle after the trigger edge
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (take) begin
            o_payload <= i_msg_word; // word written before the trigger
        end
    end

endmodule

/* record_packer/record_packer.sv */
`timescale 1ns/1ps
// record packer: fixed-priority grant (pps over msg), timestamp sample at grant,
// then header, ts low, ts high and payload on 4 consecutive strobed cycles
module record_packer import logger_pkg::*; (
    input  logic    xclk,
    input  logic    config_rst,
    input  logic    i_logger_en,
    input  logic    i_pps_rq,
    input  word_t   i_pps_payload,
    input  logic    i_msg_rq,
    input  word_t   i_msg_payload,
    input  tstamp_t i_ts_time,
    output logic    o_pps_ack,
    output logic    o_msg_ack,
    output word_t   o_data,
    output logic    o_data_stb
);

    pk_state_t state;
    logic      grant;      // idle and enabled, may accept a request
    chan_t     chan_r;     // granted channel
    tstamp_t   ts_r;       // time sampled at grant
    word_t     pay_r;
    seq_t      seq;        // record number, cleared only by reset

    assign grant     = (state == IDLE) && i_logger_en;
    assign o_pps_ack = grant && i_pps_rq;                // pps wins ties
    assign o_msg_ack = grant && i_msg_rq && !i_pps_rq;

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            state <= IDLE;
            seq   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (o_pps_ack || o_msg_ack) begin
                        state <= HDR;
                    end
                end
                HDR:     state <= TS_LO;
                TS_LO:   state <= TS_HI;
                TS_HI:   state <= PAYLOAD;
                PAYLOAD: begin
                    state <= IDLE;       // at least one idle cycle between records
                    seq   <= seq + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // capture in the ack cycle
    always_ff @(posedge xclk) begin
        if (o_pps_ack) begin
            chan_r <= CHAN_PPS;
            pay_r  <= i_pps_payload;
        end else if (o_msg_ack) begin
            chan_r <= CHAN_MSG;
            pay_r  <= i_msg_payload;
        end
        if (o_pps_ack || o_msg_ack) begin
            ts_r <= i_ts_time;
        end
    end

    always_comb begin
        case (state)
            HDR:     o_data = {chan_r, seq};          // channel in top bits
            TS_LO:   o_data = ts_r[WORD_W-1:0];
            TS_HI:   o_data = ts_r[TS_W-1:WORD_W];
            PAYLOAD: o_data = pay_r;
            default: o_data = '0;
        endcase
    end

    assign o_data_stb = (state != IDLE); // high for the 4 word states only

endmodule

/* design/event_logger.sv */
`timescale 1ns/1ps
// event logger top, single xclk domain
// register block feeds the pps and message sources, packer emits 4-word records
module event_logger import logger_pkg::*; (
    input  logic        xclk,
    input  logic        config_rst,
    input  logic        i_cfg_we,       // one-cycle register write
    input  cfg_addr_t   i_cfg_addr,
    input  logic [31:0] i_cfg_data,
    input  gpio_t       i_gpio,         // level inputs
    input  tstamp_t     i_ts_time,      // free-running local time
    output word_t       o_data,
    output logic        o_data_stb      // one per record word
);

    logic [PPS_SEL_W-1:0] pps_sel;
    logic                 pps_inv;
    logic [MSG_SEL_W-1:0] msg_sel;
    logic                 msg_inv;
    logic                 logger_en;
    word_t                msg_word;
    logic                 pps_rq;       // held until pps_ack
    logic                 msg_rq;
    logic                 pps_ack;
    logic                 msg_ack;
    word_t                pps_payload;  // stable while pps_rq
    word_t                msg_payload;

    logger_regs regs0 (
        .xclk        (xclk),
        .config_rst  (config_rst),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_data  (i_cfg_data),
        .o_pps_sel   (pps_sel),
        .o_pps_inv   (pps_inv),
        .o_msg_sel   (msg_sel),
        .o_msg_inv   (msg_inv),
        .o_logger_en (logger_en),
        .o_msg_word  (msg_word)
    );

    pps_event pps0 (
        .xclk        (xclk),
        .config_rst  (config_rst),
        .i_gpio      (i_gpio),
        .i_pps_sel   (pps_sel),
        .i_pps_inv   (pps_inv),
        .i_logger_en (logger_en),
        .i_ack       (pps_ack),
        .o_rq        (pps_rq),
        .o_payload   (pps_payload)
    );

    msg_event msg0 (
        .xclk        (xclk),
        .config_rst  (config_rst),
        .i_gpio      (i_gpio),
        .i_msg_sel   (msg_sel),
        .i_msg_inv   (msg_inv),
        .i_logger_en (logger_en),
        .i_msg_word  (msg_word),
        .i_ack       (msg_ack),
        .o_rq        (msg_rq),
        .o_payload   (msg_payload)
    );

    record_packer packer0 (
        .xclk          (xclk),
        .config_rst    (config_rst),
        .i_logger_en   (logger_en),
        .i_pps_rq      (pps_rq),
        .i_pps_payload (pps_payload),
        .i_msg_rq      (msg_rq),
        .i_msg_payload (msg_payload),
        .i_ts_time     (i_ts_time),
        .o_pps_ack     (pps_ack),
        .o_msg_ack     (msg_ack),
        .o_data        (o_data),
        .o_data_stb    (o_data_stb)
    );

endmodule

/* test/event_logger_checker.sv */
`timescale 1ns/1ps
// protocol checker for the record packer, attached by the bind below
// covers strobe length, one ack per record, request release after ack, quiet reset
module event_logger_checker import logger_pkg::*; (
    input logic xclk,
    input logic config_rst,
    input logic i_pps_rq,
    input logic i_msg_rq,
    input logic i_pps_ack,
    input logic i_msg_ack,
    input logic i_data_stb
);

    int run_len;           // strobed cycles so far in this burst
    int n_len_fail  = 0;
    int n_excl_fail = 0;
    int n_ack_fail  = 0;
    int n_rst_fail  = 0;

    always_ff @(posedge xclk) begin
        if (config_rst || !i_data_stb) begin
            run_len <= 0;
        end else begin
            run_len <= run_len + 1;
        end
    end

    // a burst never runs past 4 words and never ends early
    a_stb_len: assert property (@(posedge xclk) disable iff (config_rst)
        i_data_stb ? (run_len < RECORD_WORDS) : (run_len == 0 || run_len == RECORD_WORDS))
        else begin
            n_len_fail++;
            $error("strobe burst is not %0d cycles, run %0d", RECORD_WORDS, run_len);
        end

    // an ack starts its record next cycle and no second ack comes with it
    a_ack_excl: assert property (@(posedge xclk) disable iff (config_rst)
        (i_pps_ack || i_msg_ack) |=> (i_data_stb && !i_pps_ack && !i_msg_ack))
        else begin
            n_excl_fail++;
            $error("acknowledge not followed by a record of its own");
        end

    // source releases its request the cycle after the ack
    a_ack_rq: assert property (@(posedge xclk) disable iff (config_rst)
        !($past(i_pps_ack) && i_pps_rq) && !($past(i_msg_ack) && i_msg_rq))
        else begin
            n_ack_fail++;
            $error("request still high after its acknowledge");
        end

    a_rst_quiet: assert property (@(posedge xclk) config_rst |=> !i_data_stb)
        else begin
            n_rst_fail++;
            $error("data strobe high under reset");
        end

endmodule

bind record_packer event_logger_checker chk0 (
    .xclk       (xclk),
    .config_rst (config_rst),
    .i_pps_rq   (i_pps_rq),
    .i_msg_rq   (i_msg_rq),
    .i_pps_ack  (o_pps_ack),
    .i_msg_ack  (o_msg_ack),
    .i_data_stb (o_data_stb)
);

/* test/event_logger_tb.sv */
`timescale 1ns/1ps
// event logger testbench: scenario table applied in a loop, records checked
// against a model of the sequence number and the pps pulse count
module event_logger_tb import logger_pkg::*; ();

    localparam int N_ROWS     = 7;
    localparam int SETTLE     = DENOISE_CYCLES + 8;  // filter and sync run empty
    localparam int REC_WAIT   = 80;                  // cycles allowed for a record start
    localparam int QUIET_WAIT = 40;                  // window that must stay silent
    localparam logic [31:0] CFG_QUIET = 32'h0000_10f0; // enabled, both channels off

    logic        xclk;
    logic        config_rst;
    logic        i_cfg_we;
    cfg_addr_t   i_cfg_addr;
    logic [31:0] i_cfg_data;
    gpio_t       i_gpio;
    tstamp_t     i_ts_time;
    word_t       o_data;
    logic        o_data_stb;

    string       t_name  [N_ROWS];
    logic [31:0] t_cfg   [N_ROWS];
    word_t       t_msg   [N_ROWS];
    gpio_t       t_idle  [N_ROWS];     // pin levels outside the pulse
    gpio_t       t_pat_a [N_ROWS];
    int          t_len_a [N_ROWS];
    gpio_t       t_pat_b [N_ROWS];     // second phase, skipped for length 0
    int          t_len_b [N_ROWS];
    tstamp_t     t_ts    [N_ROWS];
    int          t_n_rec [N_ROWS];
    chan_t       t_chan  [N_ROWS][2];  // expected channel per record

    int    n_checks;
    int    n_errors;
    int    n_assert;
    seq_t  exp_seq;                    // next expected sequence number
    word_t pps_cnt;                    // pulses since the logger was enabled
    int    row;

    event_logger dut0 (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_cfg_we   (i_cfg_we),
        .i_cfg_addr (i_cfg_addr),
        .i_cfg_data (i_cfg_data),
        .i_gpio     (i_gpio),
        .i_ts_time  (i_ts_time),
        .o_data     (o_data),
        .o_data_stb (o_data_stb)
    );

    initial begin
        xclk = 1'b0;
        forever #5 xclk = ~xclk;
    end

    task automatic set_row(input int i, input string name, input logic [31:0] cfg,
                           input word_t msg, input gpio_t idle, input gpio_t pa, input int la,
                           input gpio_t pb, input int lb, input tstamp_t ts, input int n,
                           input chan_t c0, input chan_t c1);
        t_name[i]  = name;
        t_cfg[i]   = cfg;
        t_msg[i]   = msg;
        t_idle[i]  = idle;
        t_pat_a[i] = pa;
        t_len_a[i] = la;
        t_pat_b[i] = pb;
        t_len_b[i] = lb;
        t_ts[i]    = ts;
        t_n_rec[i] = n;
        t_chan[i][0] = c0;
        t_chan[i][1] = c1;
    endtask

    task automatic load_table();
        //      name              cfg       msg       idle     pat a  len pat b  len
        set_row(0, "pps_pin2",       32'h10f1, 16'h0000, 10'h000, 10'h004, 14, 10'h000, 0,
                32'h1234_5678, 1, CHAN_PPS, CHAN_PPS);
        set_row(1, "pps_glitch_inv", 32'h10f6, 16'h0000, 10'h010, 10'h000, 4, 10'h000, 0,
                32'h0bad_f00d, 0, CHAN_PPS, CHAN_PPS);  // shorter than the filter
        set_row(2, "msg_inv_pin7",   32'h1170, 16'hbeef, 10'h080, 10'h000, 5, 10'h000, 0,
                32'hdead_0001, 1, CHAN_MSG, CHAN_MSG);  // active low trigger
        set_row(3, "pps_and_msg",    32'h1051, 16'hcafe, 10'h000, 10'h004, 9, 10'h024, 8,
                32'h7fff_8000, 2, CHAN_PPS, CHAN_MSG);  // both requests rise together
        set_row(4, "msg_sel_off",    32'h11f0, 16'h5a5a, 10'h000, 10'h3ff, 6, 10'h000, 0,
                32'h0000_ffff, 0, CHAN_MSG, CHAN_MSG);
        set_row(5, "logger_off",     32'h0051, 16'h0f0f, 10'h000, 10'h024, 14, 10'h000, 0,
                32'h8000_0000, 0, CHAN_PPS, CHAN_MSG);
        set_row(6, "reenable",       32'h10f1, 16'h0000, 10'h000, 10'h004, 14, 10'h000, 0,
                32'h0102_0304, 1, CHAN_PPS, CHAN_PPS);  // numbering continues
    endtask

    task automatic write_reg(input cfg_addr_t addr, input logic [31:0] data);
        @(posedge xclk);
        i_cfg_we   <= 1'b1;
        i_cfg_addr <= addr;
        i_cfg_data <= data;
        @(posedge xclk);
        i_cfg_we   <= 1'b0;
    endtask

    task automatic check(input string name, input word_t exp, input word_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic drive_pattern(input int r);
        @(posedge xclk);
        i_gpio <= t_pat_a[r];
        repeat (t_len_a[r]) @(posedge xclk);
        if (t_len_b[r] > 0) begin
            i_gpio <= t_pat_b[r];
            repeat (t_len_b[r]) @(posedge xclk);
        end
        i_gpio <= t_idle[r];  // back to the resting level
    endtask

    task automatic collect_record(input int r, input int k);
        int    t;
        int    w;
        chan_t ch;
        word_t exp_w [RECORD_WORDS];
        t = 0;
        do begin
            @(negedge xclk);
            t++;
        end while (o_data_stb !== 1'b1 && t < REC_WAIT);
        if (o_data_stb !== 1'b1) begin
            n_errors++;
            $display("%s: record %0d did not start within %0d cycles", t_name[r], k, REC_WAIT);
        end else begin
            ch = t_chan[r][k];
            if (ch == CHAN_PPS) begin
                pps_cnt = pps_cnt + 1'b1;  // payload is the count including this pulse
            end
            exp_w[0] = {ch, exp_seq};
            exp_w[1] = t_ts[r][15:0];
            exp_w[2] = t_ts[r][31:16];
            exp_w[3] = (ch == CHAN_PPS) ? pps_cnt : t_msg[r];
            for (w = 0; w < RECORD_WORDS; w++) begin
                if (w > 0) begin
                    @(negedge xclk);
                end
                check($sformatf("%s rec%0d word%0d", t_name[r], k, w), exp_w[w], o_data);
            end
            exp_seq = exp_seq + 1'b1;
        end
    endtask

    task automatic watch_quiet(input int r);
        int t;
        int n_stb;
        n_stb = 0;
        for (t = 0; t < QUIET_WAIT; t++) begin
            @(negedge xclk);
            if (o_data_stb === 1'b1) begin
                n_stb++;
            end
        end
        if (n_stb != 0) begin
            n_errors++;
            $display("%s: %0d strobed words beyond the expected records", t_name[r], n_stb);
        end
    endtask

    task automatic collect_row(input int r);
        int k;
        for (k = 0; k < t_n_rec[r]; k++) begin
            collect_record(r, k);
        end
        watch_quiet(r);
    endtask

    initial begin
        void'($urandom(32'he1fa));
        config_rst = 1'b1;
        i_cfg_we   = 1'b0;
        i_cfg_addr = '0;
        i_cfg_data = '0;
        i_gpio     = '0;
        i_ts_time  = '0;
        n_checks   = 0;
        n_errors   = 0;
        exp_seq    = '0;
        pps_cnt    = '0;
        load_table();
        repeat (5) @(posedge xclk);
        config_rst <= 1'b0;

        for (row = 0; row < N_ROWS; row++) begin
            write_reg(ADDR_CONFIG, CFG_QUIET);    // channels off while pins move
            i_gpio    <= t_idle[row];
            i_ts_time <= t_ts[row];               // held, so the sample is known
            write_reg(ADDR_MESSAGE, {16'h0000, t_msg[row]});
            repeat (SETTLE) @(posedge xclk);
            if (t_cfg[row][CONF_EN] == 1'b0) begin
                pps_cnt = '0;                     // count restarts on disable
            end
            write_reg(ADDR_CONFIG, t_cfg[row]);
            fork
                drive_pattern(row);
                collect_row(row);
            join
            repeat (4 + $urandom % 16) @(posedge xclk);
        end

        n_assert = dut0.packer0.chk0.n_len_fail + dut0.packer0.chk0.n_excl_fail
                 + dut0.packer0.chk0.n_ack_fail + dut0.packer0.chk0.n_rst_fail;
        $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors, n_assert);
        if (n_errors == 0 && n_assert == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
common/logger_pkg.sv
design/logger_regs.sv
design/pps_event.sv
design/msg_event.sv
record_packer/record_packer.sv
design/event_logger.sv
test/event_logger_checker.sv
test/event_logger_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the event logger testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module event_logger_tb -o sim_event_logger
./obj_dir/sim_event_logger +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -qx "all tests passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
